// File: hdl/mbus_pkg.sv
/*
 * Main-bus controller shared definitions
 * Bus widths, decoded regions, FSM states and the values the
 * controller starts from after reset
 */

package mbus_pkg;

	// 68000 word address from bit 23 down to bit 1
	typedef logic [23:1] addr_t;

	typedef logic [15:0] word_t;

	typedef logic [8:0] refresh_count_t;

	typedef enum logic [1:0] {
		RGN_ROM,
		RGN_RAM,
		RGN_CTRL,
		RGN_UNMAPPED
	} region_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SELECT,
		ST_ROM_WAIT,
		ST_RAM_WAIT,
		ST_RAM_READ,
		ST_RAM_WRITE,
		ST_UNUSED,
		ST_REFRESH,
		ST_FINISH
	} mstate_t;

	// NOP opcode as seen on an undriven bus
	localparam word_t OPEN_BUS_RESET = 16'h4E71;

	// Address bits 11:8 of the sound-CPU registers
	localparam logic [3:0] CTRL_BUSREQ_PAGE = 4'd1;
	localparam logic [3:0] CTRL_RESET_PAGE  = 4'd2;
	localparam int CTRL_BIT = 8;

	localparam int REFRESH_PERIOD_DEFAULT = 384;

endpackage

// File: hdl/mbus_if.sv
/*
 * Internal main-bus link
 * Joins the cycle FSM, the datapath and the sound-CPU registers
 */

`timescale 1ns/1ps

interface mbus_if;
	import mbus_pkg::*;

	logic capture;
	addr_t a;
	word_t wdata;
	logic rnw;
	logic uds_n;
	logic lds_n;
	region_t region;
	region_t sel;
	logic active;
	logic finish;
	word_t rdata;
	logic ctrl_rdata;

	modport fsm (output capture, sel, active, finish, input region, rnw);

	modport datapath (
		input capture, sel, active, finish, ctrl_rdata,
		output a, wdata, rnw, uds_n, lds_n, region, rdata
	);

	modport ctrl (input a, wdata, rnw, uds_n, sel, active, output ctrl_rdata);

endinterface

// File: hdl/refresh_timer.sv
/*
 * DRAM refresh timer
 * Free-running counter that raises a refresh request once per
 * period and keeps it until the cycle FSM takes it
 */

`timescale 1ns/1ps

module refresh_timer #(
	parameter int REFRESH_PERIOD = mbus_pkg::REFRESH_PERIOD_DEFAULT
) (
	input  logic MCLK,
	input  logic reset,
	input  logic take,
	output logic pending
);
	import mbus_pkg::*;

	refresh_count_t count;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			count   <= '0;
			pending <= 1'b0;
		end else begin
			if (take)
				pending <= 1'b0;
			if (count == refresh_count_t'(REFRESH_PERIOD - 1)) begin
				count   <= '0;
				pending <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: hdl/mbus_fsm.sv
/*
 * Main-bus cycle FSM
 * Grants refresh or master cycles, drives the device strobes and
 * the master DTACK_N, and waits for the master to drop AS_N
 */

`timescale 1ns/1ps

module mbus_fsm (
	input  logic MCLK,
	input  logic reset,
	mbus_if.fsm  bus,
	input  logic as_n,
	input  logic uds_n,
	input  logic lds_n,
	input  logic rom_dtack_n,
	input  logic ram_rdy,
	input  logic rfs_rdy,
	input  logic pending,
	output logic take,
	output logic dtack_n,
	output logic rom_sel,
	output logic ram_ce_n,
	output logic rfs
);
	import mbus_pkg::*;

	mstate_t state;
	logic request;

	assign request = !as_n && (!uds_n || !lds_n);

	// Refresh goes ahead of a waiting master
	assign take        = (state == ST_IDLE) && pending;
	assign bus.capture = (state == ST_IDLE) && !pending && request;
	assign bus.finish  = (state == ST_FINISH) && as_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state      <= ST_IDLE;
			dtack_n    <= 1'b1;
			rom_sel    <= 1'b0;
			ram_ce_n   <= 1'b1;
			rfs        <= 1'b0;
			bus.sel    <= RGN_UNMAPPED;
			bus.active <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pending) begin
						rfs   <= 1'b1;
						state <= ST_REFRESH;
					end else if (request) begin
						state <= ST_SELECT;
					end
				end

				//----------------------------------------------------------
				// Branch on the region of the request latched on entry
				ST_SELECT: begin
					bus.sel    <= bus.region;
					bus.active <= 1'b1;
					case (bus.region)
						RGN_ROM: begin
							rom_sel <= 1'b1;
							state   <= ST_ROM_WAIT;
						end
						RGN_RAM: begin
							ram_ce_n <= 1'b0;
							state    <= ST_RAM_WAIT;
						end
						RGN_CTRL: begin
							dtack_n <= 1'b0;
							state   <= ST_FINISH;
						end
						default: state <= ST_UNUSED;
					endcase
				end

				ST_ROM_WAIT: begin
					if (!rom_dtack_n) begin
						dtack_n <= 1'b0;
						state   <= ST_FINISH;
					end
				end

				// RAM answers with a low then high RAM_RDY
				ST_RAM_WAIT: begin
					if (!ram_rdy)
						state <= bus.rnw ? ST_RAM_READ : ST_RAM_WRITE;
				end

				ST_RAM_READ: begin
					if (ram_rdy) begin
						dtack_n <= 1'b0;
						state   <= ST_FINISH;
					end
				end

				ST_RAM_WRITE: begin
					dtack_n <= 1'b0;
					state   <= ST_FINISH;
				end

				// Nothing decodes here so the open-bus word is acknowledged
				ST_UNUSED: begin
					dtack_n <= 1'b0;
					state   <= ST_FINISH;
				end

				ST_REFRESH: begin
					if (!rfs_rdy) begin
						rfs   <= 1'b0;
						state <= ST_IDLE;
					end
				end

				//----------------------------------------------------------
				// Hold DTACK_N until the master releases AS_N
				ST_FINISH: begin
					if (as_n) begin
						dtack_n    <= 1'b1;
						rom_sel    <= 1'b0;
						ram_ce_n   <= 1'b1;
						bus.active <= 1'b0;
						state      <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/mbus_datapath.sv
/*
 * Main-bus datapath
 * Latches the master request, decodes its region, selects the
 * read word and keeps the open-bus word of the last read
 */

`timescale 1ns/1ps

module mbus_datapath (
	input  logic            MCLK,
	input  logic            reset,
	mbus_if.datapath        bus,
	input  logic            uds_n,
	input  logic            lds_n,
	input  logic            rnw,
	input  mbus_pkg::addr_t addr,
	input  mbus_pkg::word_t data_in,
	input  mbus_pkg::word_t rom_data,
	input  mbus_pkg::word_t ram_data,
	output mbus_pkg::word_t data_out,
	output mbus_pkg::addr_t bus_addr,
	output mbus_pkg::word_t bus_wdata,
	output logic            bus_rnw,
	output logic            bus_uds_n,
	output logic            bus_lds_n
);
	import mbus_pkg::*;

	word_t open_bus;
	logic active_d;
	logic ctrl_page;

	always_ff @(posedge MCLK) begin
		if (bus.capture) begin
			bus.a     <= addr;
			bus.wdata <= data_in;
		end
	end

	// Strobes go back to idle once the selected cycle is over
	always_ff @(posedge MCLK) begin
		if (reset) begin
			active_d  <= 1'b0;
			bus.rnw   <= 1'b1;
			bus.uds_n <= 1'b1;
			bus.lds_n <= 1'b1;
		end else begin
			active_d <= bus.active;
			if (bus.capture) begin
				bus.rnw   <= rnw;
				bus.uds_n <= uds_n;
				bus.lds_n <= lds_n;
			end else if (active_d && !bus.active) begin
				bus.rnw   <= 1'b1;
				bus.uds_n <= 1'b1;
				bus.lds_n <= 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// Address decode
	always_comb begin
		if (!bus.a[23])
			bus.region = RGN_ROM;
		else if (&bus.a[23:21])
			bus.region = RGN_RAM;
		else if (bus.a[23:12] == 12'hA11 && bus.a[7:1] == 7'd0)
			bus.region = RGN_CTRL;
		else
			bus.region = RGN_UNMAPPED;
	end

	assign ctrl_page = (bus.a[11:8] == CTRL_BUSREQ_PAGE) || (bus.a[11:8] == CTRL_RESET_PAGE);

	// Only one bit of a control register read is real
	always_comb begin
		bus.rdata = open_bus;
		case (bus.sel)
			RGN_ROM: bus.rdata = rom_data;
			RGN_RAM: bus.rdata = ram_data;
			RGN_CTRL: begin
				if (ctrl_page)
					bus.rdata[CTRL_BIT] = bus.ctrl_rdata;
			end
			default: bus.rdata = open_bus;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset)
			open_bus <= OPEN_BUS_RESET;
		else if (bus.finish && bus.rnw)
			open_bus <= bus.rdata;
	end

	assign data_out  = bus.rdata;
	assign bus_addr  = bus.a;
	assign bus_wdata = bus.wdata;
	assign bus_rnw   = bus.rnw;
	assign bus_uds_n = bus.uds_n;
	assign bus_lds_n = bus.lds_n;

endmodule

// File: hdl/z80_ctrl.sv
/*
 * Sound-CPU control registers
 * Bus request at A11100 and reset at A11200, both on data bit 8
 */

`timescale 1ns/1ps

module z80_ctrl (
	input  logic MCLK,
	input  logic reset,
	mbus_if.ctrl bus,
	input  logic z80_busak_n,
	output logic z80_busreq_n,
	output logic z80_reset_n
);
	import mbus_pkg::*;

	logic [3:0] page;
	logic wr_en;

	assign page  = bus.a[11:8];
	assign wr_en = bus.active && (bus.sel == RGN_CTRL) && !bus.rnw && !bus.uds_n;

	// Sound CPU starts held in reset with the bus released
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else if (wr_en) begin
			if (page == CTRL_BUSREQ_PAGE)
				z80_busreq_n <= ~bus.wdata[CTRL_BIT];
			if (page == CTRL_RESET_PAGE)
				z80_reset_n <= bus.wdata[CTRL_BIT];
		end
	end

	// Other pages read back the open-bus bit in the datapath
	assign bus.ctrl_rdata = (page == CTRL_BUSREQ_PAGE) ? (z80_busak_n | ~z80_reset_n)
	                                                   : z80_reset_n;

endmodule

// File: hdl/genesis_mbus.sv
/*
 * Console main-bus controller
 * One 68000-style master, ROM, work RAM, sound-CPU control
 * registers and DRAM refresh on a single bus
 */

`timescale 1ns/1ps

module genesis_mbus #(
	parameter int REFRESH_PERIOD = mbus_pkg::REFRESH_PERIOD_DEFAULT
) (
	input  logic            MCLK,
	input  logic            reset,
	input  logic            as_n,
	input  logic            uds_n,
	input  logic            lds_n,
	input  logic            rnw,
	input  mbus_pkg::addr_t addr,
	input  mbus_pkg::word_t data_in,
	input  logic            rom_dtack_n,
	input  mbus_pkg::word_t rom_data,
	input  logic            ram_rdy,
	input  mbus_pkg::word_t ram_data,
	input  logic            rfs_rdy,
	input  logic            z80_busak_n,
	output logic            dtack_n,
	output mbus_pkg::word_t data_out,
	output mbus_pkg::addr_t bus_addr,
	output mbus_pkg::word_t bus_wdata,
	output logic            bus_rnw,
	output logic            bus_uds_n,
	output logic            bus_lds_n,
	output logic            rom_sel,
	output logic            ram_ce_n,
	output logic            rfs,
	output logic            z80_busreq_n,
	output logic            z80_reset_n
);

	logic pending;
	logic take;

	mbus_if bus_i ();

	refresh_timer #(
		.REFRESH_PERIOD(REFRESH_PERIOD)
	) refresh_timer_i (
		.MCLK(MCLK),
		.reset(reset),
		.take(take),
		.pending(pending)
	);

	mbus_fsm fsm_i (
		.MCLK(MCLK),
		.reset(reset),
		.bus(bus_i),
		.as_n(as_n),
		.uds_n(uds_n),
		.lds_n(lds_n),
		.rom_dtack_n(rom_dtack_n),
		.ram_rdy(ram_rdy),
		.rfs_rdy(rfs_rdy),
		.pending(pending),
		.take(take),
		.dtack_n(dtack_n),
		.rom_sel(rom_sel),
		.ram_ce_n(ram_ce_n),
		.rfs(rfs)
	);

	mbus_datapath datapath_i (
		.MCLK(MCLK),
		.reset(reset),
		.bus(bus_i),
		.uds_n(uds_n),
		.lds_n(lds_n),
		.rnw(rnw),
		.addr(addr),
		.data_in(data_in),
		.rom_data(rom_data),
		.ram_data(ram_data),
		.data_out(data_out),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_rnw(bus_rnw),
		.bus_uds_n(bus_uds_n),
		.bus_lds_n(bus_lds_n)
	);

	z80_ctrl z80_ctrl_i (
		.MCLK(MCLK),
		.reset(reset),
		.bus(bus_i),
		.z80_busak_n(z80_busak_n),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

endmodule

// File: test/tb_genesis_mbus.sv
/*
 * Main-bus controller testbench
 * Plays master cycles from a data file against ROM, RAM, refresh
 * and sound-CPU models, and checks read data, strobes and refresh
 */

`timescale 1ns/1ps

module tb_genesis_mbus;
	import mbus_pkg::*;

	localparam int REFRESH_PERIOD = 64;
	localparam int MAX_TESTS = 64;

	logic MCLK = 1'b0;
	logic reset;
	logic as_n, uds_n, lds_n, rnw;
	addr_t addr;
	word_t data_in;
	logic rom_dtack_n = 1'b1;
	word_t rom_data = '0;
	logic ram_rdy = 1'b1;
	word_t ram_data = '0;
	logic rfs_rdy = 1'b1;
	logic z80_busak_n = 1'b1;
	logic dtack_n, bus_rnw, bus_uds_n, bus_lds_n;
	word_t data_out, bus_wdata;
	addr_t bus_addr;
	logic rom_sel, ram_ce_n, rfs, z80_busreq_n, z80_reset_n;

	// Test table with byte addresses as in the data file
	logic [7:0] t_op [MAX_TESTS];
	logic [23:0] t_addr [MAX_TESTS];
	word_t t_wdata [MAX_TESTS];
	logic t_uds_n [MAX_TESTS];
	logic t_lds_n [MAX_TESTS];
	word_t t_exp [MAX_TESTS];
	int n_tests = 0;
	int acks = 0;
	logic dtack_prev = 1'b1;
	int limit = 0;
	int clocks = 0;
	logic running = 1'b0;

	logic [31:0] lfsr = 32'hce6d90e7;
	logic [3:0] rom_delay, ram_delay, rfs_delay;
	logic rom_armed, ram_armed, rfs_armed;
	word_t ram_mem [addr_t];
	word_t ram_word;
	logic rfs_prev = 1'b0;
	int since_refresh = 0;
	int refreshes = 0;

	genesis_mbus #(.REFRESH_PERIOD(REFRESH_PERIOD)) dut_i (.*);

	always #50 MCLK = ~MCLK;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [3:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[2:0], lfsr[0]};
		end
	endtask

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// ------------------------------------------------------------
	// Device models
	always @(posedge MCLK) begin
		rom_data <= bus_addr[16:1] ^ 16'hA5A5;
		if (reset || !rom_sel) begin
			rom_dtack_n <= 1'b1;
			rom_armed = 1'b0;
		end else if (!rom_armed) begin
			rom_armed = 1'b1;
			draw_bits(2, rom_delay);
		end else if (rom_delay == 0) begin
			rom_dtack_n <= 1'b0;
		end else begin
			rom_delay = rom_delay - 1;
		end
	end

	// Data moves when RAM_RDY falls, which then stays low 1 to 4 clocks
	always @(posedge MCLK) begin
		if (reset || ram_ce_n) begin
			ram_rdy <= 1'b1;
			ram_armed = 1'b0;
		end else if (!ram_armed) begin
			ram_armed = 1'b1;
			ram_rdy <= 1'b0;
			draw_bits(2, ram_delay);
			ram_word = ram_mem.exists(bus_addr) ? ram_mem[bus_addr] : '0;
			if (!bus_rnw) begin
				if (!bus_uds_n)
					ram_word[15:8] = bus_wdata[15:8];
				if (!bus_lds_n)
					ram_word[7:0] = bus_wdata[7:0];
				ram_mem[bus_addr] = ram_word;
			end
			ram_data <= ram_word;
		end else if (ram_delay == 0) begin
			ram_rdy <= 1'b1;
		end else begin
			ram_delay = ram_delay - 1;
		end
	end

	// RFS_RDY drops one or two clocks after RFS rises
	always @(posedge MCLK) begin
		if (reset || !rfs) begin
			rfs_rdy <= 1'b1;
			rfs_armed = 1'b0;
		end else if (!rfs_armed) begin
			rfs_armed = 1'b1;
			draw_bits(1, rfs_delay);
			if (rfs_delay == 0)
				rfs_rdy <= 1'b0;
		end else begin
			rfs_rdy <= 1'b0;
		end
	end

	always @(posedge MCLK)
		z80_busak_n <= reset ? 1'b1 : z80_busreq_n;

	// ------------------------------------------------------------
	// Refresh checks, acknowledge count and the timeout
	always @(negedge MCLK) begin
		if (!reset) begin
			assert (!(rfs && (rom_sel || !ram_ce_n)))
				else stop_run($sformatf("FAILED at %0t ns: rfs high in a device cycle", $time));
			if (rfs && !rfs_prev) begin
				refreshes++;
				since_refresh = 0;
			end else begin
				since_refresh++;
			end
			rfs_prev = rfs;
			assert (since_refresh <= REFRESH_PERIOD + 40)
				else stop_run($sformatf("FAILED at %0t ns: refresh overdue", $time));
			if (!dtack_n && dtack_prev)
				acks++;
			dtack_prev = dtack_n;
		end
	end

	always @(posedge MCLK) begin
		if (running) begin
			clocks++;
			if (clocks > limit)
				stop_run($sformatf("Timeout after %0d clocks, DTACK_N never came", clocks));
		end
	end

	task automatic run_cycle(input int idx);
		logic is_rom;
		logic is_ram;
		logic is_read;
		word_t got;
		is_rom = t_addr[idx] < 24'h800000;
		is_ram = t_addr[idx] >= 24'hE00000;
		is_read = (t_op[idx] == "r");
		@(posedge MCLK);
		addr <= t_addr[idx][23:1];
		data_in <= t_wdata[idx];
		rnw <= is_read;
		uds_n <= t_uds_n[idx];
		lds_n <= t_lds_n[idx];
		as_n <= 1'b0;
		@(negedge MCLK);
		while (dtack_n)
			@(negedge MCLK);
		got = data_out;
		assert (rom_sel == is_rom && ram_ce_n == !is_ram)
			else stop_run($sformatf("FAILED at %0t ns: wrong device strobe for %06h",
				$time, t_addr[idx]));
		assert (bus_addr == t_addr[idx][23:1] && bus_wdata == t_wdata[idx]
			&& bus_rnw == is_read && bus_uds_n == t_uds_n[idx] && bus_lds_n == t_lds_n[idx])
			else stop_run($sformatf("FAILED at %0t ns: latched request wrong for %06h",
				$time, t_addr[idx]));
		if (is_read)
			assert (got === t_exp[idx])
				else stop_run($sformatf("FAILED at %0t ns: read %06h gave %04h, expected %04h",
					$time, t_addr[idx], got, t_exp[idx]));
		@(posedge MCLK);
		as_n <= 1'b1;
		uds_n <= 1'b1;
		lds_n <= 1'b1;
		rnw <= 1'b1;
		@(negedge MCLK);
		while (!dtack_n)
			@(negedge MCLK);
		assert (!rom_sel && ram_ce_n)
			else stop_run($sformatf("FAILED at %0t ns: device strobe held after cycle", $time));
		@(negedge MCLK);
		assert (bus_rnw && bus_uds_n && bus_lds_n)
			else stop_run($sformatf("FAILED at %0t ns: bus strobes not idle after cycle", $time));
		if (!is_read && !t_uds_n[idx] && t_addr[idx] == 24'hA11100)
			assert (z80_busreq_n == !t_wdata[idx][8])
				else stop_run($sformatf("FAILED at %0t ns: z80_busreq_n wrong", $time));
		if (!is_read && !t_uds_n[idx] && t_addr[idx] == 24'hA11200)
			assert (z80_reset_n == t_wdata[idx][8])
				else stop_run($sformatf("FAILED at %0t ns: z80_reset_n wrong", $time));
	endtask

	initial begin
		int fd;
		int n;
		logic [7:0] op;
		logic [8*120-1:0] rest;
		logic [23:0] fa;
		word_t fw;
		word_t fe;
		logic fu;
		logic fl;
		reset = 1'b1;
		as_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		rnw = 1'b1;
		addr = '0;
		data_in = '0;
		fd = $fopen("test/mbus_tests.txt", "r");
		if (fd == 0)
			stop_run("Could not open the test file test/mbus_tests.txt");
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%h %h %b %b %h", fa, fw, fu, fl, fe);
				assert (n == 5) else stop_run("A line of the test file could not be parsed");
				t_op[n_tests] = op;
				t_addr[n_tests] = fa;
				t_wdata[n_tests] = fw;
				t_uds_n[n_tests] = fu;
				t_lds_n[n_tests] = fl;
				t_exp[n_tests] = fe;
				n_tests++;
			end
		end
		$fclose(fd);
		limit = 40 * n_tests + 2 * REFRESH_PERIOD;
		repeat (8) @(posedge MCLK);
		reset <= 1'b0;
		@(negedge MCLK);
		assert (dtack_n && !rfs && !rom_sel && ram_ce_n && bus_rnw && bus_uds_n && bus_lds_n
			&& z80_busreq_n && !z80_reset_n)
			else stop_run($sformatf("FAILED at %0t ns: outputs not idle after reset", $time));
		running = 1'b1;
		for (int i = 0; i < n_tests; i++)
			run_cycle(i);
		assert (acks == n_tests && n_tests > 0)
			else stop_run("The count of DTACK_N acknowledges does not match the test file");
		assert (refreshes > 0) else stop_run("No refresh cycle was seen during the run");
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: test/mbus_tests.txt
# op  byte_addr  wdata  uds_n  lds_n  expected_rdata (hex, ignored for writes)
# r = read, w = write
r 800000 0000 0 0 4E71
r 000100 0000 0 0 A525
r 800002 0000 0 0 A525
r 012346 0000 0 0 3406
w E00010 1234 0 0 0000
w E00010 AB00 0 1 0000
w E00010 00CD 1 0 0000
r E00010 0000 0 0 ABCD
w FFFFFE 5A5A 0 0 0000
r FFFFFE 0000 0 0 5A5A
r A10000 0000 0 0 5A5A
r A11100 0000 0 0 5B5A
r A11200 0000 0 0 5A5A
w A11200 0100 0 0 0000
r A11200 0000 0 0 5B5A
w A11100 0100 0 0 0000
r A11100 0000 0 0 5A5A
w A11100 0000 0 0 0000
r A11100 0000 0 0 5B5A
r C00000 0000 0 0 5B5A
r 7FFFFE 0000 0 0 5A5A
r E00010 0000 0 0 ABCD

// File: sources.f
hdl/mbus_pkg.sv
hdl/mbus_if.sv
hdl/refresh_timer.sv
hdl/mbus_fsm.sv
hdl/mbus_datapath.sv
hdl/z80_ctrl.sv
hdl/genesis_mbus.sv
test/tb_genesis_mbus.sv

// File: Bender.yml
package:
  name: genesis_mbus

sources:
  - files:
      - hdl/mbus_pkg.sv
      - hdl/mbus_if.sv
      - hdl/refresh_timer.sv
      - hdl/mbus_fsm.sv
      - hdl/mbus_datapath.sv
      - hdl/z80_ctrl.sv
      - hdl/genesis_mbus.sv
  - target: test
    files:
      - test/tb_genesis_mbus.sv
